// ==== hdl/cache_mem.sv ====
`timescale 1ns/1ps

module cache_mem (
    input  logic                    clock,
    input  logic                    reset,
    input  icache_pkg::line_addr_t  lookup_line,
    output logic                    hit,
    output icache_pkg::line_t       hit_data,
    input  icache_pkg::fill_t       demand_fill,
    input  icache_pkg::fill_t       pref_fill
);
    import icache_pkg::*;

    localparam int LINES = 2 ** INDEX_W;

    logic         valid_q [LINES];
    cache_tag_t   tag_q   [LINES];
    line_t        data_q  [LINES];
    cache_index_t look_index;

    assign look_index = line_index(lookup_line);
    assign hit        = valid_q[look_index] && (tag_q[look_index] == line_tag(lookup_line));
    assign hit_data   = data_q[look_index];

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < LINES; i++) begin
                valid_q[i] <= 1'b0;
            end
        end else begin
            if (demand_fill.valid)
                valid_q[line_index(demand_fill.line_addr)] <= 1'b1;
            if (pref_fill.valid)
                valid_q[line_index(pref_fill.line_addr)] <= 1'b1;
        end
    end

    // demand first, a prefetch fill to the same index lands on top
    always_ff @(posedge clock) begin
        if (demand_fill.valid) begin
            tag_q[line_index(demand_fill.line_addr)]  <= line_tag(demand_fill.line_addr);
            data_q[line_index(demand_fill.line_addr)] <= demand_fill.data;
        end
        if (pref_fill.valid) begin
            tag_q[line_index(pref_fill.line_addr)]  <= line_tag(pref_fill.line_addr);
            data_q[line_index(pref_fill.line_addr)] <= pref_fill.data;
        end
    end

endmodule

// ==== hdl/icache_ctrl.sv ====
`timescale 1ns/1ps

module icache_ctrl (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    fetch_req,
    input  icache_pkg::addr_t       fetch_addr,
    output logic                    fetch_ack,
    output icache_pkg::line_t       fetch_data,
    output icache_pkg::line_addr_t  lookup_line,
    input  logic                    hit,
    input  icache_pkg::line_t       hit_data,
    output icache_pkg::mem_req_t    demand_req,
    input  icache_pkg::mem_tag_t    demand_response,
    input  icache_pkg::mem_resp_t   mem_resp,
    output icache_pkg::fill_t       demand_fill,
    output icache_pkg::line_addr_t  fetch_line,
    output logic                    line_advance,
    output logic                    branch,
    input  logic                    already_fetched
);
    import icache_pkg::*;

    ctrl_state_t state;
    ctrl_state_t state_next;
    logic        req_q;         // fetch_req sampled once
    line_addr_t  cur_line;      // line of the fetch in progress
    logic        line_seen;     // low until the first fetch
    mem_tag_t    dem_tag;       // code of the outstanding demand load
    line_t       data_q;        // line held for fetch_data
    line_addr_t  new_line;
    logic        start;
    logic        dem_match;

    assign new_line  = fetch_addr[$bits(addr_t)-1:OFFSET_W];
    assign start     = (state == IDLE) && req_q;
    assign dem_match = (state == MISS_WAIT) && (mem_resp.tag != '0) && (mem_resp.tag == dem_tag);

    always_comb begin
        state_next = state;
        case (state)
            IDLE:      if (req_q) state_next = LOOKUP;
            LOOKUP: begin
                if (hit)
                    state_next = ACK;
                else if (!already_fetched)
                    state_next = MISS_REQ;   // otherwise keep looking until the prefetch fill lands
            end
            MISS_REQ:  if (demand_response != '0) state_next = MISS_WAIT;   // retry while rejected
            MISS_WAIT: if (dem_match) state_next = ACK;
            ACK:       if (!req_q) state_next = IDLE;                      // held req stalls here
            default:   state_next = IDLE;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state        <= IDLE;
            req_q        <= 1'b0;
            cur_line     <= '0;
            line_seen    <= 1'b0;
            line_advance <= 1'b0;
            branch       <= 1'b0;
        end else begin
            state        <= state_next;
            req_q        <= fetch_req;
            line_advance <= 1'b0;   // one-cycle pulses during LOOKUP
            branch       <= 1'b0;
            if (start) begin
                cur_line     <= new_line;
                line_seen    <= 1'b1;
                line_advance <= line_seen && (new_line == cur_line + 1'b1);
                // the first fetch counts as a branch so the prefetcher starts
                branch       <= !line_seen ||
                                ((new_line != cur_line) && (new_line != cur_line + 1'b1));
            end
        end
    end

    always_ff @(posedge clock) begin
        if (state == MISS_REQ)
            dem_tag <= demand_response;
        if (state == LOOKUP && hit)
            data_q <= hit_data;
        if (dem_match)
            data_q <= mem_resp.data;   // forward the demand line to fetch
    end

    always_comb begin
        demand_req.command     = (state == MISS_REQ) ? BUS_LOAD : BUS_NONE;
        demand_req.line_addr   = cur_line;
        demand_fill.valid      = dem_match;
        demand_fill.line_addr  = cur_line;
        demand_fill.data       = mem_resp.data;
    end

    assign lookup_line = cur_line;
    assign fetch_line  = cur_line;
    assign fetch_ack   = (state == ACK);
    assign fetch_data  = data_q;

endmodule

// ==== hdl/icache_pkg.sv ====
package icache_pkg;

    localparam int TAG_W              = 8;
    localparam int INDEX_W            = 5;
    localparam int OFFSET_W           = 3;     // 8-byte lines
    localparam int PREF_DEPTH_DEFAULT = 12;

    typedef logic [TAG_W+INDEX_W+OFFSET_W-1:0] addr_t;
    typedef logic [TAG_W-1:0]                  cache_tag_t;     // addr[15:8]
    typedef logic [INDEX_W-1:0]                cache_index_t;   // addr[7:3]
    typedef logic [TAG_W+INDEX_W-1:0]          line_addr_t;     // {tag, index}
    typedef logic [63:0]                       line_t;
    typedef logic [3:0]                        mem_tag_t;       // 0 = none or rejected

    typedef enum logic [1:0] {
        BUS_NONE = 2'h0,
        BUS_LOAD = 2'h1
    } bus_cmd_t;

    typedef struct packed {
        bus_cmd_t   command;
        line_addr_t line_addr;
    } mem_req_t;

    typedef struct packed {
        mem_tag_t tag;
        line_t    data;
    } mem_resp_t;

    typedef struct packed {
        logic       valid;
        line_addr_t line_addr;
        line_t      data;
    } fill_t;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        MISS_REQ,
        MISS_WAIT,
        ACK
    } ctrl_state_t;

    function automatic cache_index_t line_index(line_addr_t line);
        return line[INDEX_W-1:0];
    endfunction

    function automatic cache_tag_t line_tag(line_addr_t line);
        return line[INDEX_W +: TAG_W];
    endfunction

endpackage

// ==== hdl/icache_top.sv ====
`timescale 1ns/1ps

module icache_top #(
    parameter int PREF_DEPTH = icache_pkg::PREF_DEPTH_DEFAULT
) (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    fetch_req,
    input  icache_pkg::addr_t       fetch_addr,
    output logic                    fetch_ack,
    output icache_pkg::line_t       fetch_data,
    output icache_pkg::mem_req_t    mem_req,
    input  icache_pkg::mem_tag_t    mem_response,
    input  icache_pkg::mem_resp_t   mem_resp
);
    import icache_pkg::*;

    line_addr_t lookup_line;
    logic       hit;
    line_t      hit_data;
    mem_req_t   demand_req;
    mem_req_t   pref_req;
    mem_tag_t   demand_response;
    mem_tag_t   pref_response;
    logic       give_way;
    fill_t      demand_fill;
    fill_t      pref_fill;
    line_addr_t fetch_line;
    logic       line_advance;
    logic       branch;
    logic       already_fetched;

    icache_ctrl ctrl (
        .clock           (clock),
        .reset           (reset),
        .fetch_req       (fetch_req),
        .fetch_addr      (fetch_addr),
        .fetch_ack       (fetch_ack),
        .fetch_data      (fetch_data),
        .lookup_line     (lookup_line),
        .hit             (hit),
        .hit_data        (hit_data),
        .demand_req      (demand_req),
        .demand_response (demand_response),
        .mem_resp        (mem_resp),
        .demand_fill     (demand_fill),
        .fetch_line      (fetch_line),
        .line_advance    (line_advance),
        .branch          (branch),
        .already_fetched (already_fetched)
    );

    prefetch_engine #(
        .PREF_DEPTH (PREF_DEPTH)
    ) prefetch (
        .clock           (clock),
        .reset           (reset),
        .fetch_line      (fetch_line),
        .line_advance    (line_advance),
        .branch          (branch),
        .give_way        (give_way),
        .pref_req        (pref_req),
        .pref_response   (pref_response),
        .mem_resp        (mem_resp),
        .already_fetched (already_fetched),
        .pref_fill       (pref_fill)
    );

    cache_mem cache (
        .clock       (clock),
        .reset       (reset),
        .lookup_line (lookup_line),
        .hit         (hit),
        .hit_data    (hit_data),
        .demand_fill (demand_fill),
        .pref_fill   (pref_fill)
    );

    mem_arbiter arbiter (
        .demand_req      (demand_req),
        .pref_req        (pref_req),
        .mem_response    (mem_response),
        .mem_req         (mem_req),
        .demand_response (demand_response),
        .pref_response   (pref_response),
        .give_way        (give_way)
    );

endmodule

// ==== hdl/mem_arbiter.sv ====
`timescale 1ns/1ps

module mem_arbiter (
    input  icache_pkg::mem_req_t  demand_req,
    input  icache_pkg::mem_req_t  pref_req,
    input  icache_pkg::mem_tag_t  mem_response,
    output icache_pkg::mem_req_t  mem_req,
    output icache_pkg::mem_tag_t  demand_response,
    output icache_pkg::mem_tag_t  pref_response,
    output logic                  give_way
);
    import icache_pkg::*;

    logic demand_load;
    logic pref_load;

    assign demand_load = (demand_req.command == BUS_LOAD);
    assign pref_load   = (pref_req.command == BUS_LOAD);

    always_comb begin
        if (demand_load) begin
            mem_req         = demand_req;     // demand owns the bus
            demand_response = mem_response;
            pref_response   = '0;
        end else begin
            mem_req         = pref_req;       // BUS_NONE when idle
            demand_response = '0;
            pref_response   = mem_response;
        end
    end

    assign give_way = demand_load && pref_load;   // prefetch lost this cycle

endmodule

// ==== hdl/prefetch_engine.sv ====
`timescale 1ns/1ps

module prefetch_engine #(
    parameter int PREF_DEPTH = icache_pkg::PREF_DEPTH_DEFAULT
) (
    input  logic                    clock,
    input  logic                    reset,
    input  icache_pkg::line_addr_t  fetch_line,
    input  logic                    line_advance,
    input  logic                    branch,
    input  logic                    give_way,
    output icache_pkg::mem_req_t    pref_req,
    input  icache_pkg::mem_tag_t    pref_response,
    input  icache_pkg::mem_resp_t   mem_resp,
    output logic                    already_fetched,
    output icache_pkg::fill_t       pref_fill
);
    import icache_pkg::*;

    localparam int CNT_W  = $clog2(PREF_DEPTH + 1);
    localparam int SLOT_W = (PREF_DEPTH > 1) ? $clog2(PREF_DEPTH) : 1;

    logic [CNT_W-1:0]  count;                    // lines requested ahead of fetch_line
    logic [CNT_W-1:0]  count_eff;                // count after this cycle's branch or advance
    logic              active;                   // set by the first fetch
    mem_tag_t          slot_tag  [PREF_DEPTH];   // 0 marks a free slot
    line_addr_t        slot_line [PREF_DEPTH];
    line_addr_t        target;
    logic              want;
    logic              dup;
    logic              issue;
    logic              accepted;
    logic              step;
    logic              free_found;
    logic [SLOT_W-1:0] free_slot;
    logic              fill_hit;
    logic [SLOT_W-1:0] fill_slot;

    always_comb begin
        if (branch)
            count_eff = '0;              // slots stay, stray fills still land
        else if (line_advance && count != '0)
            count_eff = count - 1'b1;
        else
            count_eff = count;

        target = fetch_line + line_addr_t'(count_eff) + 1'b1;
        want   = active && !branch && (count_eff < PREF_DEPTH);

        dup             = 1'b0;
        already_fetched = 1'b0;
        free_found      = 1'b0;
        free_slot       = '0;
        fill_hit        = 1'b0;
        fill_slot       = '0;
        for (int i = 0; i < PREF_DEPTH; i++) begin
            if (slot_tag[i] != '0) begin
                if (slot_line[i] == target)
                    dup = 1'b1;              // still outstanding from an older window
                if (slot_line[i] == fetch_line)
                    already_fetched = 1'b1;
                if (mem_resp.tag == slot_tag[i]) begin
                    fill_hit  = 1'b1;
                    fill_slot = SLOT_W'(i);
                end
            end else if (!free_found) begin
                free_found = 1'b1;
                free_slot  = SLOT_W'(i);
            end
        end

        issue    = want && !dup && free_found;
        accepted = issue && !give_way && (pref_response != '0);
        // a duplicate counts as requested without going to the bus
        step     = accepted || (want && dup);

        pref_req.command    = issue ? BUS_LOAD : BUS_NONE;
        pref_req.line_addr  = target;
        pref_fill.valid     = fill_hit;
        pref_fill.line_addr = slot_line[fill_slot];
        pref_fill.data      = mem_resp.data;
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            count  <= '0;
            active <= 1'b0;
            for (int i = 0; i < PREF_DEPTH; i++) begin
                slot_tag[i] <= '0;
            end
        end else begin
            count <= count_eff + CNT_W'(step);
            if (branch)
                active <= 1'b1;
            if (fill_hit)
                slot_tag[fill_slot] <= '0;
            if (accepted)
                slot_tag[free_slot] <= pref_response;   // free slot never equals fill slot
        end
    end

    always_ff @(posedge clock) begin
        if (accepted)
            slot_line[free_slot] <= target;
    end

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the instruction-cache testbench with Verilator and run it from the project root
cd "$(dirname "$0")" &&
verilator --binary --timing -f src.f --top-module icache_tb -o icache_sim &&
./obj_dir/icache_sim | tee /dev/stderr | grep -q "Simulation finished: PASS" &&
echo "run_sim: testbench reported success" ||
{ echo "run_sim: testbench failed or did not build"; exit 1; }

// ==== src.f ====
hdl/icache_pkg.sv
hdl/mem_arbiter.sv
hdl/cache_mem.sv
hdl/prefetch_engine.sv
hdl/icache_ctrl.sv
hdl/icache_top.sv
tests/icache_checker.sv
tests/icache_tb.sv

// ==== tests/icache_checker.sv ====
`timescale 1ns/1ps

module icache_checker #(
    parameter int PREF_DEPTH = icache_pkg::PREF_DEPTH_DEFAULT
) (
    input logic                   clock,
    input logic                   reset,
    input logic                   fetch_req,
    input icache_pkg::addr_t      fetch_addr,
    input logic                   fetch_ack,
    input icache_pkg::line_t      fetch_data,
    input icache_pkg::mem_req_t   mem_req,
    input icache_pkg::mem_tag_t   mem_response,
    input icache_pkg::mem_resp_t  mem_resp,
    input logic [127:0]           test_name,
    input icache_pkg::line_t      expect_data
);
    import icache_pkg::*;

    localparam logic [63:0] LINE_MULT = 64'h9e3779b97f4a7c15;

    int         error_count = 0;
    int         done_count  = 0;
    int         pass_count  = 0;
    int         fail_count  = 0;
    logic       reset_q     = 1'b0;
    logic       reset_qq    = 1'b0;
    logic       ack_prev;
    logic       req_prev;           // fetch_req as it was when ack last changed
    line_addr_t cur_line;           // line of the latest fetch request
    line_addr_t prev_line;          // previous line that the DUT may still prefetch from
    logic       code_busy [16];     // accepted loads not yet returned
    line_addr_t code_line [16];

    function automatic logic in_window(line_addr_t line, line_addr_t base);
        line_addr_t diff;
        diff = line - base;
        return int'(diff) <= PREF_DEPTH;
    endfunction

    task automatic check_line();
        line_t rule;
        rule = 64'(fetch_addr[$bits(addr_t)-1:OFFSET_W]) * LINE_MULT;
        done_count++;
        if (rule != expect_data) begin
            $display("golden entry %0s disagrees with the memory contents for address %h",
                     test_name, fetch_addr);
            error_count++;
        end
        if (fetch_data !== expect_data) begin
            $display("MISMATCH test %0s expected %h actual %h", test_name, expect_data, fetch_data);
            fail_count++;
            error_count++;
        end else begin
            $display("test %0s: ok, line %h", test_name, fetch_data);
            pass_count++;
        end
    endtask

    task automatic print_totals();
        $display("fetches: %0d passed, %0d failed, %0d errors in total",
                 pass_count, fail_count, error_count);
    endtask

    // outputs are quiet from reset until one cycle after it
    always @(negedge clock) begin
        if ((reset_q || reset_qq) && (fetch_ack !== 1'b0 || mem_req.command !== BUS_NONE)) begin
            $display("reset: fetch_ack or the memory command is active around reset");
            error_count++;
        end
    end

    always @(posedge clock) begin
        reset_q  <= reset;
        reset_qq <= reset_q;
        if (reset) begin
            ack_prev  <= 1'b0;
            req_prev  <= 1'b0;
            cur_line  <= '0;
            prev_line <= '0;
            for (int i = 0; i < 16; i++) begin
                code_busy[i] = 1'b0;
            end
        end else begin
            if (fetch_ack && !ack_prev && !req_prev) begin
                $display("handshake: fetch_ack rose while fetch_req was low");
                error_count++;
            end
            if (!fetch_ack && ack_prev && req_prev) begin
                $display("handshake: fetch_ack fell while fetch_req was still high");
                error_count++;
            end
            if (fetch_ack && !ack_prev)
                check_line();
            ack_prev <= fetch_ack;
            req_prev <= fetch_req;
            if (fetch_req && fetch_addr[$bits(addr_t)-1:OFFSET_W] != cur_line) begin
                prev_line <= cur_line;
                cur_line  <= fetch_addr[$bits(addr_t)-1:OFFSET_W];
            end

            if (mem_resp.tag != '0)
                code_busy[mem_resp.tag] = 1'b0;   // code is free again once returned
            if (mem_req.command == BUS_LOAD) begin
                if (!in_window(mem_req.line_addr, cur_line) &&
                    !in_window(mem_req.line_addr, prev_line)) begin
                    $display("prefetch window: load of line %h is outside the window of line %h",
                             mem_req.line_addr, cur_line);
                    error_count++;
                end
                if (mem_response != '0) begin
                    for (int i = 1; i < 16; i++) begin
                        if (code_busy[i] && code_line[i] == mem_req.line_addr) begin
                            $display("duplicate: line %h loaded again while code %0d is outstanding",
                                     mem_req.line_addr, i);
                            error_count++;
                        end
                    end
                    code_busy[mem_response] = 1'b1;
                    code_line[mem_response] = mem_req.line_addr;
                end
            end
        end
    end

endmodule

// ==== tests/icache_golden.txt ====
# columns: test name, fetch byte address (hex), expected 64-bit line (hex)
# runs: sequential 12 lines, forward jump, backward jump to cached lines, second run
seq_a01 000c 9e3779b97f4a7c15
seq_a02 0010 3c6ef372fe94f82a
seq_a03 0018 daa66d2c7ddf743f
seq_a04 0020 78dde6e5fd29f054
seq_a05 0028 1715609f7c746c69
seq_a06 0030 b54cda58fbbee87e
seq_a07 003c 538454127b096493
seq_a08 0040 f1bbcdcbfa53e0a8
seq_a09 0048 8ff34785799e5cbd
seq_a10 0050 2e2ac13ef8e8d8d2
seq_a11 0058 cc623af8783354e7
seq_a12 0060 6a99b4b1f77dd0fc
jump_fwd 08cc aae49c9cb8c2330d
back_08 0040 f1bbcdcbfa53e0a8
back_09 0048 8ff34785799e5cbd
back_10 0054 2e2ac13ef8e8d8d2
seq_b01 08d0 491c1656380caf22
seq_b02 08d8 e753900fb7572b37
seq_b03 08e0 858b09c936a1a74c
seq_b04 08e8 23c28382b5ec2361
seq_b05 08f0 c1f9fd3c35369f76
seq_b06 08f8 603176f5b4811b8b
seq_b07 0900 fe68f0af33cb97a0
seq_b08 0908 9ca06a68b31613b5

// ==== tests/icache_tb.sv ====
`timescale 1ns/1ps

module icache_tb;
    import icache_pkg::*;

    localparam int          PREF_DEPTH   = PREF_DEPTH_DEFAULT;
    localparam int          MAX_ENTRIES  = 64;
    localparam int          RESET_CYCLES = 16;
    localparam logic [63:0] LINE_MULT    = 64'h9e3779b97f4a7c15;

    logic         clock;
    logic         reset;
    logic         fetch_req;
    addr_t        fetch_addr;
    logic         fetch_ack;
    line_t        fetch_data;
    mem_req_t     mem_req;
    mem_tag_t     mem_response;
    mem_resp_t    mem_resp;
    logic [127:0] cur_name;
    line_t        cur_expect;

    logic [127:0] names   [MAX_ENTRIES];
    addr_t        addrs   [MAX_ENTRIES];
    line_t        expects [MAX_ENTRIES];
    int           entries     = 0;
    int           cycle_limit = 0;
    int           cycle_count = 0;
    logic [31:0]  lfsr;
    logic         code_busy [16];   // memory side view of outstanding codes
    int           code_wait [16];   // cycles left until the data returns
    line_addr_t   code_line [16];

    icache_top #(
        .PREF_DEPTH (PREF_DEPTH)
    ) dut (
        .clock        (clock),
        .reset        (reset),
        .fetch_req    (fetch_req),
        .fetch_addr   (fetch_addr),
        .fetch_ack    (fetch_ack),
        .fetch_data   (fetch_data),
        .mem_req      (mem_req),
        .mem_response (mem_response),
        .mem_resp     (mem_resp)
    );

    icache_checker #(
        .PREF_DEPTH (PREF_DEPTH)
    ) checks (
        .clock        (clock),
        .reset        (reset),
        .fetch_req    (fetch_req),
        .fetch_addr   (fetch_addr),
        .fetch_ack    (fetch_ack),
        .fetch_data   (fetch_data),
        .mem_req      (mem_req),
        .mem_response (mem_response),
        .mem_resp     (mem_resp),
        .test_name    (cur_name),
        .expect_data  (cur_expect)
    );

    function automatic line_t memory_line(line_addr_t line);
        return 64'(line) * LINE_MULT;
    endfunction

    function automatic logic take_bit();
        logic b;
        b    = lfsr[0];
        lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hd0000001) : (lfsr >> 1);   // galois step
        return b;
    endfunction

    task automatic run_fetch(input logic [127:0] name, input addr_t addr, input line_t expect_line);
        @(negedge clock);
        cur_name   = name;
        cur_expect = expect_line;
        fetch_addr = addr;
        fetch_req  = 1'b1;
        do @(negedge clock); while (!fetch_ack);
        fetch_req = 1'b0;
        do @(negedge clock); while (fetch_ack);
    endtask

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    // memory answers a load in the same cycle and returns the data 2 to 9 cycles later
    always @(negedge clock) begin : memory_model
        logic       b0;
        logic       b1;
        logic [2:0] d;
        int         ret;
        int         code;
        if (reset) begin
            for (int i = 0; i < 16; i++) begin
                code_busy[i] = 1'b0;
                code_wait[i] = 0;
            end
            mem_response = '0;
            mem_resp     = '0;
        end else begin
            ret = 0;
            for (int i = 1; i < 16; i++) begin
                if (code_busy[i] && code_wait[i] > 0)
                    code_wait[i]--;
            end
            for (int i = 15; i >= 1; i--) begin
                if (code_busy[i] && code_wait[i] == 0)
                    ret = i;                     // lowest ready code returns first
            end
            mem_resp = '0;
            if (ret != 0) begin
                mem_resp.tag  = 4'(ret);
                mem_resp.data = memory_line(code_line[ret]);
            end
            mem_response = '0;
            if (mem_req.command == BUS_LOAD) begin
                b0 = take_bit();
                b1 = take_bit();
                if (!(b0 && b1)) begin
                    code = 0;
                    for (int i = 15; i >= 1; i--) begin
                        if (!code_busy[i])
                            code = i;
                    end
                    if (code != 0) begin
                        d[0] = take_bit();
                        d[1] = take_bit();
                        d[2] = take_bit();
                        code_busy[code] = 1'b1;
                        code_wait[code] = 2 + int'(d);
                        code_line[code] = mem_req.line_addr;
                        mem_response    = 4'(code);
                    end
                end
            end
            if (ret != 0)
                code_busy[ret] = 1'b0;   // freed only after this cycle's allocation
        end
    end

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
            $display("timeout: the fetch sequence did not finish within %0d cycles", cycle_limit);
            checks.print_totals();
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    initial begin : stimulus
        int           fd;
        int           n;
        string        text;
        logic [127:0] name_v;
        addr_t        addr_v;
        line_t        data_v;
        lfsr         = 32'h7a7f82ae;
        reset        = 1'b1;
        fetch_req    = 1'b0;
        fetch_addr   = '0;
        mem_response = '0;
        mem_resp     = '0;
        cur_name     = '0;
        cur_expect   = '0;
        fd = $fopen("tests/icache_golden.txt", "r");
        if (fd == 0) begin
            $display("could not open tests/icache_golden.txt");
            $display("Simulation finished: FAIL");
            $finish;
        end else begin
            while (!$feof(fd) && entries < MAX_ENTRIES) begin
                n = $fgets(text, fd);
                if (n > 0 && text.len() > 1 && text[0] != "#") begin
                    n = $sscanf(text, "%s %h %h", name_v, addr_v, data_v);
                    if (n == 3) begin
                        names[entries]   = name_v;
                        addrs[entries]   = addr_v;
                        expects[entries] = data_v;
                        entries++;
                    end
                end
            end
            $fclose(fd);
            cycle_limit = entries * 40 + 200;

            repeat (RESET_CYCLES) @(posedge clock);
            @(negedge clock);
            reset = 1'b0;

            for (int i = 0; i < entries; i++) begin
                run_fetch(names[i], addrs[i], expects[i]);
            end
            repeat (4) @(negedge clock);

            checks.print_totals();
            if (entries > 0 && checks.error_count == 0 && checks.done_count == entries) begin
                $display("Simulation finished: PASS");
            end else begin
                $display("Simulation finished: FAIL");
            end
            $finish;
        end
    end

endmodule
